// ==== verilog/ex_pkg.sv ====
/* Execute stage shared types */

package ex_pkg;

  // Datapath and register-file widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 6;

  // Number of ALU replicas behind the voter
  localparam int N_REPLICA  = 4;

  // Outvote counter width per replica
  localparam int CNT_W      = 9;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE
  } alu_op_e;

  // Voted execute-stage operation
  typedef enum logic [2:0] {
    EX_NONE, EX_ALU, EX_MUL, EX_MULH, EX_CSR, EX_BRANCH, EX_LOAD
  } ex_op_e;

  // Write-back source on the forward port
  typedef enum logic [1:0] {
    WB_NONE, WB_ALU, WB_MULT, WB_CSR
  } wb_src_e;

  // One request copy per ALU replica
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] operand_c;
  } alu_req_t;

  // Control after the ID-stage vote
  typedef struct packed {
    ex_op_e                op;
    logic [XLEN-1:0]       mult_a;
    logic [XLEN-1:0]       mult_b;
    logic [REG_ADDR_W-1:0] rd_alu;
    logic                  rd_alu_we;
    logic [REG_ADDR_W-1:0] rd_lsu;
    logic                  rd_lsu_we;
  } ex_ctrl_t;

  // Register-file write port for forward and WB
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } fwd_port_t;

endpackage

// ==== verilog/ex_op_decode.sv ====
/* Execute operation decode */

`timescale 1ns/10ps

module ex_op_decode
  import ex_pkg::*;
(
  input  ex_op_e  op_i,
  output wb_src_e wb_src_o,
  output logic    mult_start_o,
  output logic    mult_high_o
);

  // Purely combinational map from voted op to datapath controls
  always_comb begin
    wb_src_o     = WB_NONE;
    mult_start_o = 1'b0;
    mult_high_o  = 1'b0;

    case (op_i)
      // Plain ALU result on the forward port
      EX_ALU: begin
        wb_src_o = WB_ALU;
      end
      // Low product, done in the same cycle
      EX_MUL: begin
        wb_src_o     = WB_MULT;
        mult_start_o = 1'b1;
      end
      // High product needs the extra cycle
      EX_MULH: begin
        wb_src_o     = WB_MULT;
        mult_start_o = 1'b1;
        mult_high_o  = 1'b1;
      end
      // CSR read data goes out on the ALU port
      EX_CSR: begin
        wb_src_o = WB_CSR;
      end
      // Branch resolves in EX, load writes back through the WB port
      EX_BRANCH, EX_LOAD: begin
        wb_src_o = WB_NONE;
      end
      default: begin
        wb_src_o = WB_NONE;
      end
    endcase
  end

endmodule

// ==== verilog/alu_replica.sv ====
/* Integer ALU replica */

`timescale 1ns/10ps

module alu_replica
  import ex_pkg::*;
(
  input  alu_req_t        req_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // Only the low five bits count for a 32-bit shift
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  // Comparison result, also the branch decision
  always_comb begin
    case (req_i.op)
      ALU_EQ:   cmp_o = (op_a == op_b);
      ALU_NE:   cmp_o = (op_a != op_b);
      ALU_SLT:  cmp_o = lt_signed;
      ALU_SLTU: cmp_o = lt_unsigned;
      default:  cmp_o = 1'b0;
    endcase
  end

  // Main result
  always_comb begin
    case (req_i.op)
      ALU_ADD:  result_o = op_a + op_b;
      ALU_SUB:  result_o = op_a - op_b;
      ALU_AND:  result_o = op_a & op_b;
      ALU_OR:   result_o = op_a | op_b;
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_SLL:  result_o = op_a << shamt;
      ALU_SRL:  result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
      // Set-less-than and compares return 0 or 1
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE: begin
        result_o = {{(XLEN-1){1'b0}}, cmp_o};
      end
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== verilog/alu_vote.sv ====
/* Quad ALU with majority vote */

`timescale 1ns/10ps

module alu_vote
  import ex_pkg::*;
#(
  parameter int FAULT_THRESHOLD = 255
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  alu_req_t [N_REPLICA-1:0]      alu_req_i,
  input  logic [1:0]                    sel_excl_i,
  input  logic                          enable_i,
  output logic [XLEN-1:0]               result_o,
  output logic                          cmp_o,
  output logic                          err_detected_o,
  output logic                          err_corrected_o,
  output logic [N_REPLICA-1:0]          permanent_fault_o,
  output logic [N_REPLICA-1:0]          fault_event_o
);

  logic [N_REPLICA-1:0][XLEN-1:0]  rep_result;
  logic [N_REPLICA-1:0]            rep_cmp;
  // Result and comparison voted as one word
  logic [N_REPLICA-1:0][XLEN:0]    vote_val;
  logic [XLEN:0]                   vote_out;
  logic [1:0]                      idx0, idx1, idx2;
  logic                            m01, m02, m12;
  logic [N_REPLICA-1:0]            outvote;
  logic [N_REPLICA-1:0]            outvote_en;
  logic [N_REPLICA-1:0][CNT_W-1:0] cnt_q, cnt_d;
  logic [N_REPLICA-1:0]            perm_q, perm_d;
  logic [N_REPLICA-1:0]            event_q;

  ////////////////////
  // Replicas
  ////////////////////
  for (genvar g = 0; g < N_REPLICA; g++) begin : g_replica
    alu_replica u_alu (
      .req_i    (alu_req_i[g]),
      .result_o (rep_result[g]),
      .cmp_o    (rep_cmp[g])
    );
    assign vote_val[g] = {rep_cmp[g], rep_result[g]};
  end

  ////////////////////
  // Voter
  ////////////////////
  // Three voting replicas in ascending order, skipping the excluded one
  assign idx0 = (sel_excl_i == 2'd0) ? 2'd1 : 2'd0;
  assign idx1 = (sel_excl_i <= 2'd1) ? 2'd2 : 2'd1;
  assign idx2 = (sel_excl_i <= 2'd2) ? 2'd3 : 2'd2;

  assign m01 = (vote_val[idx0] == vote_val[idx1]);
  assign m02 = (vote_val[idx0] == vote_val[idx2]);
  assign m12 = (vote_val[idx1] == vote_val[idx2]);

  always_comb begin
    vote_out        = vote_val[idx0];
    err_detected_o  = 1'b0;
    err_corrected_o = 1'b0;
    outvote         = '0;
    if (m01 && m12) begin
      // Unanimous
      vote_out = vote_val[idx0];
    end else if (m01) begin
      // Third replica is the odd one
      err_detected_o  = 1'b1;
      err_corrected_o = 1'b1;
      outvote[idx2]   = 1'b1;
    end else if (m02) begin
      err_detected_o  = 1'b1;
      err_corrected_o = 1'b1;
      outvote[idx1]   = 1'b1;
    end else if (m12) begin
      // First replica outvoted, take the majority
      vote_out        = vote_val[idx1];
      err_detected_o  = 1'b1;
      err_corrected_o = 1'b1;
      outvote[idx0]   = 1'b1;
    end else begin
      // No majority, lowest selected replica passes through
      err_detected_o = 1'b1;
    end
  end

  assign result_o = vote_out[XLEN-1:0];
  assign cmp_o    = vote_out[XLEN];

  ////////////////////
  // Outvote counters
  ////////////////////
  assign outvote_en = outvote & {N_REPLICA{enable_i}};

  always_comb begin
    for (int i = 0; i < N_REPLICA; i++) begin
      cnt_d[i] = cnt_q[i];
      // Saturate at all ones
      if (outvote_en[i] && (cnt_q[i] != '1)) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // Sticky once the threshold is hit
      perm_d[i] = perm_q[i] | (cnt_d[i] >= CNT_W'(FAULT_THRESHOLD));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      perm_q  <= '0;
      event_q <= '0;
    end else begin
      cnt_q   <= cnt_d;
      perm_q  <= perm_d;
      event_q <= outvote_en;
    end
  end

  assign permanent_fault_o = perm_q;
  assign fault_event_o     = event_q;

endmodule

// ==== verilog/mult_unit.sv ====
/* Unsigned multiplier */

`timescale 1ns/10ps

module mult_unit
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            high_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            ex_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            ready_o
);

  typedef enum logic {
    MULT_IDLE,
    MULT_HIGH
  } mult_state_e;

  mult_state_e       state_q, state_d;
  logic [2*XLEN-1:0] product;
  // High half captured for the second cycle
  logic [XLEN-1:0]   prod_high_q;

  assign product = op_a_i * op_b_i;

  always_comb begin
    state_d  = state_q;
    ready_o  = 1'b1;
    result_o = product[XLEN-1:0];
    case (state_q)
      MULT_IDLE: begin
        // MULH stalls the stage for one cycle
        if (start_i && high_i) begin
          ready_o = 1'b0;
          state_d = MULT_HIGH;
        end
      end
      MULT_HIGH: begin
        result_o = prod_high_q;
        // Hold the product until the stage moves on
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE && start_i && high_i) begin
      prod_high_q <= product[2*XLEN-1:XLEN];
    end
  end

endmodule

// ==== verilog/ex_result.sv ====
/* Write ports and EX/WB register */

`timescale 1ns/10ps

module ex_result
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  ex_ctrl_t        ctrl_i,
  input  wb_src_e         wb_src_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic [XLEN-1:0] mult_result_i,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] lsu_rdata_i,
  input  logic            mult_ready_i,
  input  logic            lsu_err_i,
  input  logic            lsu_ready_i,
  input  logic            wb_ready_i,
  output fwd_port_t       fwd_o,
  output fwd_port_t       wb_o,
  output logic            ex_ready_o,
  output logic            ex_valid_o
);

  logic                  all_ready;
  logic                  is_branch;
  logic                  wb_we_q;
  logic [REG_ADDR_W-1:0] wb_waddr_q;

  ////////////////////
  // Forward port
  ////////////////////
  always_comb begin
    fwd_o.we    = ctrl_i.rd_alu_we && (wb_src_i != WB_NONE);
    fwd_o.waddr = ctrl_i.rd_alu;
    case (wb_src_i)
      WB_ALU:  fwd_o.wdata = alu_result_i;
      WB_MULT: fwd_o.wdata = mult_result_i;
      WB_CSR:  fwd_o.wdata = csr_rdata_i;
      default: fwd_o.wdata = '0;
    endcase
  end

  ////////////////////
  // Stall control
  ////////////////////
  assign all_ready = mult_ready_i & lsu_ready_i & wb_ready_i;
  assign is_branch = (ctrl_i.op == EX_BRANCH);

  // Branches finish in EX, so they never wait on WB
  assign ex_ready_o = all_ready | is_branch;
  assign ex_valid_o = (ctrl_i.op != EX_NONE) & ~is_branch & all_ready;

  ////////////////////
  // EX/WB register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // Faulting load never reaches the register file
      wb_we_q <= ctrl_i.rd_lsu_we & ~lsu_err_i;
      if (ctrl_i.rd_lsu_we && !lsu_err_i) begin
        wb_waddr_q <= ctrl_i.rd_lsu;
      end
    end else if (wb_ready_i) begin
      // WB idle and nothing new, flush the slot
      wb_we_q <= 1'b0;
    end
  end

  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  // Load data arrives from the LSU in the WB cycle
  assign wb_o.wdata = lsu_rdata_i;

endmodule

// ==== verilog/ex_stage.sv ====
/* Fault-tolerant execute stage */

`timescale 1ns/10ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int FAULT_THRESHOLD = 255
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  alu_req_t [N_REPLICA-1:0] alu_req_i,
  input  ex_ctrl_t                 ctrl_i,
  input  logic [1:0]               sel_excl_i,
  input  logic [XLEN-1:0]          csr_rdata_i,
  input  logic [XLEN-1:0]          lsu_rdata_i,
  input  logic                     lsu_err_i,
  input  logic                     lsu_ready_i,
  input  logic                     wb_ready_i,
  output fwd_port_t                fwd_o,
  output fwd_port_t                wb_o,
  output logic                     branch_decision_o,
  output logic [XLEN-1:0]          jump_target_o,
  output logic                     err_detected_o,
  output logic                     err_corrected_o,
  output logic [N_REPLICA-1:0]     permanent_fault_o,
  output logic [N_REPLICA-1:0]     fault_event_o,
  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  wb_src_e         wb_src;
  logic            mult_start;
  logic            mult_high;
  logic            alu_en;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  ex_op_decode u_decode (
    .op_i         (ctrl_i.op),
    .wb_src_o     (wb_src),
    .mult_start_o (mult_start),
    .mult_high_o  (mult_high)
  );

  // Outvotes only count when the ALU result is actually used
  assign alu_en = (ctrl_i.op == EX_ALU) || (ctrl_i.op == EX_BRANCH);

  alu_vote #(
    .FAULT_THRESHOLD (FAULT_THRESHOLD)
  ) u_alu_vote (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req_i),
    .sel_excl_i        (sel_excl_i),
    .enable_i          (alu_en),
    .result_o          (alu_result),
    .cmp_o             (alu_cmp),
    .err_detected_o    (err_detected_o),
    .err_corrected_o   (err_corrected_o),
    .permanent_fault_o (permanent_fault_o),
    .fault_event_o     (fault_event_o)
  );

  // Branch resolution straight to IF
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i[0].operand_c;

  // Multiplier takes the voted operands, held by ex_ready_o
  mult_unit u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (mult_start),
    .high_i     (mult_high),
    .op_a_i     (ctrl_i.mult_a),
    .op_b_i     (ctrl_i.mult_b),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ex_result u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .wb_src_i      (wb_src),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .mult_ready_i  (mult_ready),
    .lsu_err_i     (lsu_err_i),
    .lsu_ready_i   (lsu_ready_i),
    .wb_ready_i    (wb_ready_i),
    .fwd_o         (fwd_o),
    .wb_o          (wb_o),
    .ex_ready_o    (ex_ready_o),
    .ex_valid_o    (ex_valid_o)
  );

endmodule

// ==== verification/ex_stage_checker.sv ====
/* Execute stage assertions */

`timescale 1ns/10ps

module ex_stage_checker
  import ex_pkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 err_detected_i,
  input logic                 err_corrected_i,
  input logic                 wb_we_i,
  input logic [N_REPLICA-1:0] fault_event_i,
  input logic [N_REPLICA-1:0] permanent_fault_i
);

  // Number of assertion failures so far
  int assert_fails = 0;

  // A correction is always also a detection
  corrected_implies_detected: assert property (
    @(posedge clk) disable iff (!rst_n) err_corrected_i |-> err_detected_i
  ) else begin
    assert_fails++;
    $error("err_corrected_o high while err_detected_o is low");
  end

  // Registered outputs stay cleared in reset
  quiet_in_reset: assert property (
    @(posedge clk) !rst_n |-> (!wb_we_i && fault_event_i == '0)
  ) else begin
    assert_fails++;
    $error("wb_o.we or fault_event_o active during reset");
  end

  // Permanent fault flags are sticky
  permanent_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
      (($past(permanent_fault_i) & ~permanent_fault_i) == '0)
  ) else begin
    assert_fails++;
    $error("permanent_fault_o bit cleared without reset");
  end

endmodule

bind ex_stage ex_stage_checker u_checker (
  .clk               (clk),
  .rst_n             (rst_n),
  .err_detected_i    (err_detected_o),
  .err_corrected_i   (err_corrected_o),
  .wb_we_i           (wb_o.we),
  .fault_event_i     (fault_event_o),
  .permanent_fault_i (permanent_fault_o)
);

// ==== verification/ex_stage_tb.sv ====
/* Execute stage testbench */

`timescale 1ns/10ps

module ex_stage_tb
  import ex_pkg::*;
();

  localparam int THRESHOLD = 4;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // Iterations per test group
  localparam int N_ALU   = 40;
  localparam int N_FAULT = 16;
  localparam int N_MUL   = 12;
  localparam int N_LOAD  = 12;
  localparam int N_CSR   = 8;
  localparam int N_STALL = 10;
  localparam int TEST_CYCLES = 3 * 4 + N_ALU + N_FAULT + 2 * THRESHOLD + 3 * N_MUL
                               + 2 * N_LOAD + N_CSR + 2 * N_STALL + 8;

  // Expected vote outcome and write data
  typedef struct packed {
    logic            det;
    logic            corr;
    logic            cmp;
    logic [XLEN-1:0] data;
  } ref_t;

  logic                     clk;
  logic                     rst_n;
  alu_req_t [N_REPLICA-1:0] alu_req;
  ex_ctrl_t                 ctrl;
  logic [1:0]               sel_excl;
  logic [XLEN-1:0]          csr_rdata;
  logic [XLEN-1:0]          lsu_rdata;
  logic                     lsu_err;
  logic                     lsu_ready;
  logic                     wb_ready;
  fwd_port_t                fwd_o;
  fwd_port_t                wb_o;
  logic                     branch_decision_o;
  logic [XLEN-1:0]          jump_target_o;
  logic                     err_detected_o;
  logic                     err_corrected_o;
  logic [N_REPLICA-1:0]     permanent_fault_o;
  logic [N_REPLICA-1:0]     fault_event_o;
  logic                     ex_ready_o;
  logic                     ex_valid_o;

  logic [31:0] lfsr = 32'hc2d2;
  int          n_checks = 0;
  int          n_errors = 0;

  ex_stage #(
    .FAULT_THRESHOLD (THRESHOLD)
  ) u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .ctrl_i            (ctrl),
    .sel_excl_i        (sel_excl),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_err_i         (lsu_err),
    .lsu_ready_i       (lsu_ready),
    .wb_ready_i        (wb_ready),
    .fwd_o             (fwd_o),
    .wb_o              (wb_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .err_detected_o    (err_detected_o),
    .err_corrected_o   (err_corrected_o),
    .permanent_fault_o (permanent_fault_o),
    .fault_event_o     (fault_event_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////
  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Single replica model returning {cmp, result}
  function automatic logic [XLEN:0] alu_model(input alu_req_t r);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic            cmp;
    a   = r.operand_a;
    b   = r.operand_b;
    cmp = 1'b0;
    res = '0;
    case (r.op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a + ~b + 32'd1;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLL:  res = a << b[4:0];
      ALU_SRL:  res = a >> b[4:0];
      // Sign fill of the vacated upper bits
      ALU_SRA:  res = (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0);
      ALU_SLT:  cmp = (a[31] != b[31]) ? a[31] : (a < b);
      ALU_SLTU: cmp = a < b;
      ALU_EQ:   cmp = (a == b);
      ALU_NE:   cmp = (a != b);
      default:  res = '0;
    endcase
    if (r.op inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE}) begin
      res = {31'h0, cmp};
    end
    return {cmp, res};
  endfunction

  // Vote over the three selected replicas, then pick the write source
  function automatic ref_t ref_result(input alu_req_t [N_REPLICA-1:0] req,
                                      input logic [1:0] excl, input ex_ctrl_t c,
                                      input logic [XLEN-1:0] csr);
    logic [N_REPLICA-1:0][XLEN:0] v;
    logic [XLEN:0]                voted;
    logic [2*XLEN-1:0]            prod;
    int                           idx[3];
    int                           n;
    ref_t                         r;
    n = 0;
    r = '0;
    for (int i = 0; i < N_REPLICA; i++) begin
      v[i] = alu_model(req[i]);
      if (i != excl) begin
        idx[n] = i;
        n++;
      end
    end
    voted = v[idx[0]];
    if (v[idx[0]] == v[idx[1]] && v[idx[1]] == v[idx[2]]) begin
      voted = v[idx[0]];
    end else if (v[idx[0]] == v[idx[1]] || v[idx[0]] == v[idx[2]]) begin
      r.det  = 1'b1;
      r.corr = 1'b1;
    end else if (v[idx[1]] == v[idx[2]]) begin
      voted  = v[idx[1]];
      r.det  = 1'b1;
      r.corr = 1'b1;
    end else begin
      r.det = 1'b1;
    end
    r.cmp = voted[XLEN];
    prod  = {32'h0, c.mult_a} * {32'h0, c.mult_b};
    case (c.op)
      EX_MUL:  r.data = prod[XLEN-1:0];
      EX_MULH: r.data = prod[2*XLEN-1:XLEN];
      EX_CSR:  r.data = csr;
      default: r.data = voted[XLEN-1:0];
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    ctrl      = '0;
    alu_req   = '0;
    sel_excl  = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    lsu_err   = 1'b0;
    lsu_ready = 1'b1;
    wb_ready  = 1'b1;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Same random request on every replica with EX_ALU control
  task automatic drive_alu(input alu_op_e op);
    alu_req_t r;
    r.op        = op;
    r.operand_a = next_bits(32);
    r.operand_b = next_bits(32);
    r.operand_c = next_bits(32);
    for (int i = 0; i < N_REPLICA; i++) begin
      alu_req[i] = r;
    end
    ctrl           = '0;
    ctrl.op        = EX_ALU;
    ctrl.rd_alu    = next_bits(REG_ADDR_W);
    ctrl.rd_alu_we = 1'b1;
  endtask

  task automatic print_counts();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, u_dut.u_checker.assert_fails);
  endtask

  ////////////////////
  // Compare process
  ////////////////////
  always @(negedge clk) begin : compare
    ref_t exp;
    if (rst_n) begin
      exp = ref_result(alu_req, sel_excl, ctrl, csr_rdata);
      if (ex_valid_o && (ctrl.op == EX_ALU || ctrl.op == EX_MUL ||
                         ctrl.op == EX_MULH || ctrl.op == EX_CSR)) begin
        check_value("fwd_o.wdata", fwd_o.wdata, exp.data);
        check_value("fwd_o.we", fwd_o.we, ctrl.rd_alu_we);
        check_value("fwd_o.waddr", fwd_o.waddr, ctrl.rd_alu);
      end
      if (ex_valid_o && ctrl.op == EX_ALU) begin
        check_value("err_detected_o", err_detected_o, exp.det);
        check_value("err_corrected_o", err_corrected_o, exp.corr);
      end
      // Branch resolves whatever the WB side does
      if (ctrl.op == EX_BRANCH) begin
        check_value("branch_decision_o", branch_decision_o, exp.cmp);
        check_value("jump_target_o", jump_target_o, alu_req[0].operand_c);
        check_value("ex_ready_o", ex_ready_o, 1'b1);
      end
    end
  end

  initial begin
    #(TEST_CYCLES * 20);
    $display("Timeout: the tests did not finish within %0d ns", TEST_CYCLES * 20);
    print_counts();
    $display("Regression failed");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin : stimulus
    int                    victim;
    logic                  err_bit;
    logic [REG_ADDR_W-1:0] load_addr;
    drive_idle();
    apply_reset();

    // Random ops on identical replicas
    for (int i = 0; i < N_ALU; i++) begin
      step();
      drive_alu(alu_op_e'(next_bits(4) % 12));
      sel_excl = next_bits(2);
    end

    // Corrupt either a voting or the excluded replica
    for (int i = 0; i < N_FAULT; i++) begin
      step();
      drive_alu(alu_op_e'(next_bits(4) % 12));
      sel_excl = next_bits(2);
      if (i % 2 == 0) begin
        victim = (int'(sel_excl) + 1 + int'(next_bits(2)) % 3) % N_REPLICA;
      end else begin
        victim = sel_excl;
      end
      alu_req[victim].operand_a = alu_req[victim].operand_a ^ (next_bits(32) | 32'h1);
    end

    // Outvote replica 2 up to the threshold
    step();
    drive_idle();
    apply_reset();
    for (int k = 0; k < THRESHOLD; k++) begin
      drive_alu(ALU_ADD);
      alu_req[2].operand_a = alu_req[2].operand_a ^ 32'h10;
      @(negedge clk);
      check_value("fault_event_o", fault_event_o, 4'b0000);
      step();
      drive_alu(ALU_ADD);
      @(negedge clk);
      check_value("fault_event_o", fault_event_o, 4'b0100);
      check_value("permanent_fault_o", permanent_fault_o,
                  (k + 1 >= THRESHOLD) ? 4'b0100 : 4'b0000);
      step();
    end

    // MUL finishes at once and MULH stalls one cycle
    for (int i = 0; i < N_MUL; i++) begin
      drive_idle();
      ctrl.op        = EX_MUL;
      ctrl.mult_a    = next_bits(32);
      ctrl.mult_b    = next_bits(32);
      ctrl.rd_alu    = next_bits(REG_ADDR_W);
      ctrl.rd_alu_we = 1'b1;
      step();
      ctrl.op     = EX_MULH;
      ctrl.mult_a = next_bits(32);
      ctrl.mult_b = next_bits(32);
      @(negedge clk);
      check_value("ex_valid_o", ex_valid_o, 1'b0);
      step();
      @(negedge clk);
      check_value("ex_valid_o", ex_valid_o, 1'b1);
      step();
    end

    // Loads through the EX/WB register
    for (int i = 0; i < N_LOAD; i++) begin
      drive_idle();
      load_addr      = next_bits(REG_ADDR_W);
      err_bit        = next_bits(1);
      ctrl.op        = EX_LOAD;
      ctrl.rd_lsu    = load_addr;
      ctrl.rd_lsu_we = 1'b1;
      lsu_err        = err_bit;
      @(negedge clk);
      check_value("ex_valid_o", ex_valid_o, 1'b1);
      step();
      drive_idle();
      lsu_rdata = next_bits(32);
      @(negedge clk);
      check_value("wb_o.we", wb_o.we, !err_bit);
      if (!err_bit) begin
        check_value("wb_o.waddr", wb_o.waddr, load_addr);
      end
      check_value("wb_o.wdata", wb_o.wdata, lsu_rdata);
      step();
    end

    // CSR read data on the forward port
    for (int i = 0; i < N_CSR; i++) begin
      drive_idle();
      ctrl.op        = EX_CSR;
      ctrl.rd_alu    = next_bits(REG_ADDR_W);
      ctrl.rd_alu_we = 1'b1;
      csr_rdata      = next_bits(32);
      step();
    end

    // Branches still resolve under WB back-pressure
    for (int i = 0; i < N_STALL; i++) begin
      drive_alu(alu_op_e'(next_bits(4) % 12));
      wb_ready = 1'b0;
      @(negedge clk);
      check_value("ex_valid_o", ex_valid_o, 1'b0);
      check_value("ex_ready_o", ex_ready_o, 1'b0);
      step();
      drive_alu(next_bits(1) ? ALU_EQ : ALU_NE);
      ctrl.op  = EX_BRANCH;
      wb_ready = 1'b0;
      if (next_bits(1)) begin
        for (int r = 0; r < N_REPLICA; r++) begin
          alu_req[r].operand_b = alu_req[r].operand_a;
        end
      end
      @(negedge clk);
      check_value("ex_valid_o", ex_valid_o, 1'b0);
      step();
    end

    drive_idle();
    repeat (2) @(posedge clk);
    print_counts();
    if (n_errors == 0 && u_dut.u_checker.assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/ex_pkg.sv
verilog/ex_op_decode.sv
verilog/alu_replica.sv
verilog/alu_vote.sv
verilog/mult_unit.sv
verilog/ex_result.sv
verilog/ex_stage.sv
verification/ex_stage_checker.sv
verification/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  # Design
  - files:
      - verilog/ex_pkg.sv
      - verilog/ex_op_decode.sv
      - verilog/alu_replica.sv
      - verilog/alu_vote.sv
      - verilog/mult_unit.sv
      - verilog/ex_result.sv
      - verilog/ex_stage.sv

  # Verification
  - target: test
    files:
      - verification/ex_stage_checker.sv
      - verification/ex_stage_tb.sv
